//--- camCfg.f
+incdir+src
src/camCfgPkg.sv
src/i2cByteEngine.sv
src/i2cTransaction.sv
src/cfgSequencer.sv
src/camCfgTop.sv
tests/i2cSensorModel.sv
tests/camCfg_chk.sv
tests/camCfgTb.sv

//--- Bender.yml
package:
  name: camCfg

sources:
  - include_dirs:
      - src
    files:
      - src/camCfgPkg.sv
      - src/i2cByteEngine.sv
      - src/i2cTransaction.sv
      - src/cfgSequencer.sv
      - src/camCfgTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/i2cSensorModel.sv
      - tests/camCfg_chk.sv
      - tests/camCfgTb.sv

//--- tests/camCfgTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "camCfg_params.svh"

module camCfgTb
   import camCfgPkg::*;
();

   localparam real PERIOD = 4.0;

   logic clk;
   logic resetN;
   wire  scl;
   wire  sda;
   wire  camReady;
   int   seed = 63575;
   int   wrongIds;
   int   nackIdx;
   int   errors = 0;
   int   testsRun = 0;
   int   testsFailed = 0;
   int   cycles = 0;
   int   cycleLimit;
   int   errsBefore;
   int   expIdx [$];   // script index of each register write
   int   w;
   int   pos;
   int   lenAtReady;
   realtime gap;

   pullup (scl);
   pullup (sda);

   camCfgTop dut_i (.CLK_400K (clk), .RESET_N (resetN), .I2C_SCL (scl), .I2C_SDA (sda),
                    .camReady (camReady));

   i2cSensorModel model_i (.scl (scl), .sda (sda), .wrongIds (wrongIds), .nackWrite (nackIdx));

   always #2 clk = ~clk;

   // two times three script passes plus the id retries
   function automatic int runLimit();
      int bitCyc;
      int idCyc;
      int passCyc;
      bitCyc  = 4 * `SCL_QUARTER;
      idCyc   = (3 * 9 + 2) * bitCyc + (2 * 9 + 2) * bitCyc;
      passCyc = idCyc;
      for (int i = 0; i < 12; i++) begin
         if (CAM_SCRIPT[i].kind == regWrite) passCyc += (4 * 9 + 2) * bitCyc;
         else if (CAM_SCRIPT[i].kind == delay) passCyc += CAM_SCRIPT[i].value * `DELAY_UNIT;
      end
      return 2 * (3 * passCyc + 4 * (idCyc + `RETRY_WAIT));
   endfunction

   task automatic valueError(input string msg);
      $display("error at %0t ns: %s", $time, msg);
      errors++;
   endtask

   task automatic missingEvent(input string msg);
      $display("%s", msg);
      errors++;
   endtask

   task automatic endTest(input string name);
      testsRun++;
      if (errors == errsBefore) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: failed", name);
         testsFailed++;
      end
      errsBefore = errors;
   endtask

   // compares one log entry with the write at script index sIdx
   task automatic compareWrite(input int logPos, input int sIdx);
      assert (model_i.logDev[logPos] == CAM_SCRIPT[sIdx].devAddr &&
              model_i.logReg[logPos] == CAM_SCRIPT[sIdx].regAddr &&
              model_i.logData[logPos] == CAM_SCRIPT[sIdx].value)
         else valueError($sformatf("write %0d is %h:%h=%h, expected entry %0d", logPos,
                         model_i.logDev[logPos], model_i.logReg[logPos],
                         model_i.logData[logPos], sIdx));
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > cycleLimit) begin
         $display("run stopped, camReady never rose within %0d cycles", cycleLimit);
         $display("TB FAILED");
         $finish;
      end
   end

   initial begin
      clk        = 1'b0;
      resetN     = 1'b0;
      cycleLimit = runLimit();
      wrongIds   = $unsigned($random(seed)) % 4;
      for (int i = 0; i < 12; i++) if (CAM_SCRIPT[i].kind == regWrite) expIdx.push_back(i);
      nackIdx    = $unsigned($random(seed)) % expIdx.size();
      errsBefore = 0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      assert (scl === 1'b1 && sda === 1'b1 && camReady === 1'b0)
         else valueError("bus not released or camReady high in reset");
      @(posedge clk);
      resetN <= 1'b1;
      endTest("reset");

      while (camReady !== 1'b1) @(negedge clk);
      lenAtReady = model_i.logLen;

      assert (model_i.protoErrs == 0)
         else valueError($sformatf("%0d malformed identity transfers", model_i.protoErrs));
      assert (model_i.idReads == wrongIds + 2)
         else valueError($sformatf("%0d id reads, expected %0d", model_i.idReads, wrongIds + 2));
      if (lenAtReady == 0) begin
         missingEvent("no register write reached the sensor");
      end else begin
         // first logged write follows the restart when write 0 is nacked
         assert (model_i.logIdReads[0] == ((nackIdx == 0) ? wrongIds + 2 : wrongIds + 1))
            else valueError("register write before the good id");
      end
      endTest("identity");

      if (lenAtReady != nackIdx + expIdx.size()) begin
         valueError($sformatf("%0d writes logged, expected %0d", lenAtReady,
                    nackIdx + expIdx.size()));
      end else begin
         for (int i = 0; i < nackIdx; i++) compareWrite(i, expIdx[i]);
         for (int i = 0; i < expIdx.size(); i++) compareWrite(nackIdx + i, expIdx[i]);
      end
      endTest("script");

      for (int d = 0; d < 12; d++) begin
         if (CAM_SCRIPT[d].kind == delay) begin
            w = 0;
            for (int i = 0; i < d; i++) if (CAM_SCRIPT[i].kind == regWrite) w++;
            pos = nackIdx + w - 1;
            if (w == 0) begin
            end else if (pos + 1 >= lenAtReady) begin
               missingEvent("no write after a delay entry");
            end else begin
               gap = model_i.logStart[pos + 1] - model_i.logStop[pos];
               assert (gap >= CAM_SCRIPT[d].value * `DELAY_UNIT * PERIOD)
                  else valueError($sformatf("delay gap %0t ns too short", gap));
            end
         end
      end
      endTest("delay");

      assert (model_i.nackUsed && model_i.writeCount == nackIdx + 1 + expIdx.size())
         else valueError("nacked write not followed by exactly one full pass");
      if (lenAtReady > nackIdx) begin
         assert (model_i.logIdReads[nackIdx] == wrongIds + 2)
            else valueError("no identity check between nack and restart");
      end
      repeat (64) @(negedge clk);
      assert (camReady === 1'b1 && scl === 1'b1 && sda === 1'b1)
         else valueError("camReady dropped or bus active after ready");
      assert (model_i.logLen == lenAtReady && !model_i.active)
         else valueError("bus traffic after camReady");
      endTest("restart");

      if (dut_i.chk_i.assertFails != 0) begin
         missingEvent("concurrent assertions failed during the run");
         testsFailed++;
      end
      $display("summary: %0d tests, %0d failed, %0d errors, %0d assertion failures",
               testsRun, testsFailed, errors, dut_i.chk_i.assertFails);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/camCfg_chk.sv
`timescale 1ns/1ps
`default_nettype none

module camCfg_chk
   import camCfgPkg::*;
(
   input wire       CLK_400K,
   input wire       RESET_N,
   input wire       I2C_SCL,
   input wire       I2C_SDA,
   input wire       camReady,
   input seqState_e seqState
);
   int   assertFails = 0;
   logic busBusy;   // between a start and its stop

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) busBusy <= 1'b0;
      else if (I2C_SCL && $past(I2C_SCL) && $fell(I2C_SDA)) busBusy <= 1'b1;
      else if (I2C_SCL && $past(I2C_SCL) && $rose(I2C_SDA)) busBusy <= 1'b0;
   end

   aResetPins: assert property (@(posedge CLK_400K) !RESET_N |-> I2C_SCL && I2C_SDA)
      else begin $error("bus pin driven low in reset"); assertFails++; end
   aResetReady: assert property (@(posedge CLK_400K) !RESET_N |=> !camReady)
      else begin $error("camReady high after a reset cycle"); assertFails++; end
   aAfterReset: assert property (@(posedge CLK_400K)
      $rose(RESET_N) |-> I2C_SCL && I2C_SDA && !camReady)
      else begin $error("bus or camReady wrong right after reset"); assertFails++; end
   // sda edge with scl high is only a start from idle or a stop of a transfer
   aStartOnly: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      (I2C_SCL && $past(I2C_SCL) && $fell(I2C_SDA)) |-> !busBusy)
      else begin $error("sda fell with scl high inside a transfer"); assertFails++; end
   aStopOnly: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      (I2C_SCL && $past(I2C_SCL) && $rose(I2C_SDA)) |-> busBusy)
      else begin $error("sda rose with scl high outside a transfer"); assertFails++; end
   aReadyHold: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      camReady |=> camReady)
      else begin $error("camReady dropped"); assertFails++; end
   aReadyIdle: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      camReady |-> I2C_SCL && I2C_SDA && seqState == cfgDone)
      else begin $error("bus busy or sequencer active with camReady"); assertFails++; end

endmodule

bind camCfgTop camCfg_chk chk_i (
   .CLK_400K (CLK_400K), .RESET_N (RESET_N), .I2C_SCL (I2C_SCL), .I2C_SDA (I2C_SDA),
   .camReady (camReady), .seqState (seq_i.state)
);

`default_nettype wire

//--- tests/i2cSensorModel.sv
`timescale 1ns/1ps
`default_nettype none
`include "camCfg_params.svh"

module i2cSensorModel
   import camCfgPkg::*;
(
   input  wire scl,
   inout  wire sda,
   input  int  wrongIds,    // wrong id replies before the good one
   input  int  nackWrite    // register write whose data byte gets a nack
);
   logic       driveLow = 1'b0;
   logic       active = 1'b0;
   logic       firstFall;      // scl fall that closes the start
   logic       isRead;
   logic       nackUsed = 1'b0;
   logic       nackThis;
   logic       ptrSeen = 1'b0; // id pointer written, read may follow
   logic [7:0] shiftReg;
   logic [7:0] idByte;
   logic [7:0] xferBytes [0:3];
   int         bitIdx;
   int         byteIdx;
   int         wrongSent = 0;
   int         idReads = 0;
   int         writeCount = 0; // register writes seen, the nacked one too
   int         protoErrs = 0;
   int         logLen = 0;
   logic [7:0]  logDev [0:63];
   logic [15:0] logReg [0:63];
   logic [7:0]  logData [0:63];
   int          logIdReads [0:63];
   realtime     logStart [0:63];
   realtime     logStop [0:63];
   realtime     xferStart;

   assign sda = driveLow ? 1'b0 : 1'bz;

   always @(negedge sda) begin
      if (scl === 1'b1) begin   // start
         active    = 1'b1;
         firstFall = 1'b1;
         bitIdx    = 0;
         byteIdx   = 0;
         nackThis  = 1'b0;
         xferStart = $realtime;
      end
   end

   always @(posedge scl) begin
      if (active && bitIdx < 8) shiftReg = {shiftReg[6:0], sda !== 1'b0};
   end

   always @(negedge scl) begin
      if (!active) begin
      end else if (firstFall) begin
         firstFall = 1'b0;
      end else if (bitIdx == 7) begin
         if (byteIdx < 4) xferBytes[byteIdx] = shiftReg;
         if (byteIdx == 0) begin
            isRead = shiftReg[0];
            idByte = (wrongSent < wrongIds) ? (`CAM_ID_VALUE ^ 8'h5a) : `CAM_ID_VALUE;
         end
         if (isRead && byteIdx == 1) begin
            driveLow = 1'b0;   // master answers this one
         end else if (!isRead && byteIdx == 3 && writeCount == nackWrite && !nackUsed) begin
            driveLow = 1'b0;
            nackUsed = 1'b1;
            nackThis = 1'b1;
         end else begin
            driveLow = 1'b1;   // ack
         end
         bitIdx = 8;
      end else if (bitIdx == 8) begin
         bitIdx   = 0;
         byteIdx  = byteIdx + 1;
         driveLow = (isRead && byteIdx == 1) ? !idByte[7] : 1'b0;
      end else begin
         bitIdx   = bitIdx + 1;
         driveLow = (isRead && byteIdx == 1) ? !idByte[7 - bitIdx] : 1'b0;
      end
   end

   always @(posedge sda) begin
      if (scl === 1'b1 && active) begin   // stop
         active   = 1'b0;
         driveLow = 1'b0;
         if (isRead) begin
            if (byteIdx != 2 || !ptrSeen || xferBytes[0] != (`CAM_I2C_ADDR | 8'h01))
               protoErrs++;
            idReads++;
            if (idByte != `CAM_ID_VALUE) wrongSent++;
            ptrSeen = 1'b0;
         end else if (byteIdx == 3) begin
            if (xferBytes[0] != `CAM_I2C_ADDR || {xferBytes[1], xferBytes[2]} != `CAM_ID_REG)
               protoErrs++;
            ptrSeen = 1'b1;
         end else if (byteIdx == 4) begin
            ptrSeen = 1'b0;
            writeCount++;
            if (!nackThis) begin
               logDev[logLen]     = xferBytes[0];
               logReg[logLen]     = {xferBytes[1], xferBytes[2]};
               logData[logLen]    = xferBytes[3];
               logIdReads[logLen] = idReads;
               logStart[logLen]   = xferStart;
               logStop[logLen]    = $realtime;
               logLen++;
            end
         end else begin
            protoErrs++;   // transfer of an unexpected length
         end
      end
   end

endmodule

`default_nettype wire

//--- src/camCfgTop.sv
`timescale 1ns/1ps
`default_nettype none

module camCfgTop
   import camCfgPkg::*;
(
   input  logic CLK_400K,
   input  logic RESET_N,
   output logic I2C_SCL,
   inout  wire  I2C_SDA,
   output logic camReady
);
   i2cReq_t    req;
   logic       reqValid;
   logic       reqDone;
   i2cRsp_t    rsp;
   byteCmd_e   cmd;
   logic       cmdValid;
   logic [7:0] txByte;
   logic       cmdDone;
   logic [7:0] rxByte;
   logic       ackIn;
   logic       sclOut;
   logic       sdaOut;
   logic       sdaIn;

   // scl driven high when released, no stretching
   assign I2C_SCL = (sclOut || !RESET_N) ? 1'b1 : 1'b0;
   assign I2C_SDA = (sdaOut || !RESET_N) ? 1'bz : 1'b0;   // open drain
   assign sdaIn   = I2C_SDA;

   cfgSequencer seq_i (
      .CLK_400K (CLK_400K), .RESET_N (RESET_N), .req (req), .reqValid (reqValid),
      .reqDone (reqDone), .rsp (rsp), .camReady (camReady)
   );

   i2cTransaction xact_i (
      .CLK_400K (CLK_400K), .RESET_N (RESET_N), .req (req), .reqValid (reqValid),
      .reqDone (reqDone), .rsp (rsp), .cmd (cmd), .cmdValid (cmdValid), .txByte (txByte),
      .cmdDone (cmdDone), .rxByte (rxByte), .ackIn (ackIn)
   );

   i2cByteEngine byte_i (
      .CLK_400K (CLK_400K), .RESET_N (RESET_N), .cmd (cmd), .cmdValid (cmdValid),
      .cmdDone (cmdDone), .txByte (txByte), .rxByte (rxByte), .ackIn (ackIn),
      .sclOut (sclOut), .sdaOut (sdaOut), .sdaIn (sdaIn)
   );

endmodule

`default_nettype wire

//--- src/cfgSequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "camCfg_params.svh"

module cfgSequencer
   import camCfgPkg::*;
(
   input  logic    CLK_400K,
   input  logic    RESET_N,
   output i2cReq_t req,
   output logic    reqValid,
   input  logic    reqDone,
   input  i2cRsp_t rsp,
   output logic    camReady
);
   seqState_e    state;
   logic         reqPending;   // request out, waiting for reqDone
   logic [3:0]   scriptIdx;
   logic [15:0]  delayCnt;     // script delays and retry idle
   scriptEntry_t entry;
   scriptEntry_t nextEntry;

   assign nextEntry = CAM_SCRIPT[scriptIdx];

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state      <= idPtr;
         reqValid   <= 1'b0;
         reqPending <= 1'b0;
         scriptIdx  <= 4'd0;
         delayCnt   <= 16'd0;
         camReady   <= 1'b0;
      end else begin
         reqValid <= 1'b0;
         if (reqDone) reqPending <= 1'b0;

         if (reqDone && rsp.ackErr) begin
            // any nack restarts from the identity check
            state    <= retryWait;
            delayCnt <= 16'(`RETRY_WAIT);
         end else begin
            case (state)
               idPtr: begin
                  if (!reqPending) begin
                     req <= '{op: writePtr, devAddr: `CAM_I2C_ADDR,
                              regAddr: `CAM_ID_REG, wrData: 8'h00};
                     reqValid   <= 1'b1;
                     reqPending <= 1'b1;
                  end else if (reqDone) begin
                     state <= idRead;
                  end
               end
               idRead: begin
                  if (!reqPending) begin
                     req <= '{op: readByte, devAddr: `CAM_I2C_ADDR,
                              regAddr: `CAM_ID_REG, wrData: 8'h00};
                     reqValid   <= 1'b1;
                     reqPending <= 1'b1;
                  end else if (reqDone) begin
                     state <= idCheck;
                  end
               end
               idCheck: begin
                  if (rsp.rdData == `CAM_ID_VALUE) begin
                     scriptIdx <= 4'd0;
                     state     <= fetch;
                  end else begin
                     state    <= retryWait;
                     delayCnt <= 16'(`RETRY_WAIT);
                  end
               end
               fetch: begin
                  entry <= nextEntry;
                  case (nextEntry.kind)
                     regWrite: state <= regWr;
                     delay: begin
                        delayCnt <= 16'(nextEntry.value) * 16'(`DELAY_UNIT);
                        state    <= delayWait;
                     end
                     default: state <= cfgDone;
                  endcase
               end
               regWr: begin
                  if (!reqPending) begin
                     req <= '{op: writeReg, devAddr: entry.devAddr,
                              regAddr: entry.regAddr, wrData: entry.value};
                     reqValid   <= 1'b1;
                     reqPending <= 1'b1;
                  end else if (reqDone) begin
                     scriptIdx <= scriptIdx + 4'd1;
                     state     <= fetch;
                  end
               end
               delayWait: begin
                  if (delayCnt == 16'd0) begin
                     scriptIdx <= scriptIdx + 4'd1;
                     state     <= fetch;
                  end else begin
                     delayCnt <= delayCnt - 16'd1;
                  end
               end
               retryWait: begin
                  if (delayCnt == 16'd0) state <= idPtr;
                  else delayCnt <= delayCnt - 16'd1;
               end
               default: camReady <= 1'b1;   // script done, hold here
            endcase
         end
      end
   end

endmodule

`default_nettype wire

//--- src/i2cTransaction.sv
`timescale 1ns/1ps
`default_nettype none

module i2cTransaction
   import camCfgPkg::*;
(
   input  logic       CLK_400K,
   input  logic       RESET_N,
   input  i2cReq_t    req,
   input  logic       reqValid,
   output logic       reqDone,
   output i2cRsp_t    rsp,
   output byteCmd_e   cmd,
   output logic       cmdValid,
   output logic [7:0] txByte,
   input  logic       cmdDone,
   input  logic [7:0] rxByte,
   input  logic       ackIn
);
   typedef enum logic [1:0] {xIdle, xIssue, xWait} xactState_e;

   xactState_e state;
   logic [2:0] step;
   logic       nackSeen;      // rest of the transfer is only a stop
   logic [7:0] rdData;
   logic       ackErr;
   logic [7:0] addrByte;
   byteCmd_e   curCmd;
   logic [7:0] curByte;

   assign addrByte = {req.devAddr[7:1], req.op == readByte};

   // byte command for the current step of the opcode
   always_comb begin
      curCmd  = stop;
      curByte = 8'h00;
      if (nackSeen) begin
         curCmd = stop;
      end else if (step == 3'd0) begin
         curCmd = start;
      end else if (step == 3'd1) begin
         curCmd  = sendByte;
         curByte = addrByte;
      end else if (req.op == readByte) begin
         curCmd = (step == 3'd2) ? recvByte : stop;   // master nacks the one byte
      end else begin
         case (step)
            3'd2: begin
               curCmd  = sendByte;
               curByte = req.regAddr[15:8];
            end
            3'd3: begin
               curCmd  = sendByte;
               curByte = req.regAddr[7:0];
            end
            3'd4: begin
               curCmd  = (req.op == writeReg) ? sendByte : stop;
               curByte = req.wrData;
            end
            default: curCmd = stop;
         endcase
      end
   end

   assign cmd    = curCmd;
   assign txByte = curByte;
   assign rsp    = '{rdData: rdData, ackErr: ackErr};

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state    <= xIdle;
         step     <= 3'd0;
         nackSeen <= 1'b0;
         cmdValid <= 1'b0;
         reqDone  <= 1'b0;
         ackErr   <= 1'b0;
      end else begin
         cmdValid <= 1'b0;
         reqDone  <= 1'b0;
         case (state)
            xIdle: if (reqValid) begin
               step     <= 3'd0;
               nackSeen <= 1'b0;
               state    <= xIssue;
            end
            xIssue: begin
               cmdValid <= 1'b1;
               state    <= xWait;
            end
            xWait: if (cmdDone) begin
               if (curCmd == stop) begin
                  reqDone <= 1'b1;
                  ackErr  <= nackSeen;
                  state   <= xIdle;
               end else begin
                  if (curCmd == sendByte && !ackIn) nackSeen <= 1'b1;
                  step  <= step + 3'd1;
                  state <= xIssue;
               end
            end
            default: state <= xIdle;
         endcase
      end
   end

   always_ff @(posedge CLK_400K) begin
      if (state == xWait && cmdDone && curCmd == recvByte) rdData <= rxByte;
   end

endmodule

`default_nettype wire

//--- src/i2cByteEngine.sv
`timescale 1ns/1ps
`default_nettype none
`include "camCfg_params.svh"

module i2cByteEngine
   import camCfgPkg::*;
(
   input  logic       CLK_400K,
   input  logic       RESET_N,
   input  byteCmd_e   cmd,
   input  logic       cmdValid,
   output logic       cmdDone,
   input  logic [7:0] txByte,
   output logic [7:0] rxByte,
   output logic       ackIn,
   output logic       sclOut,
   output logic       sdaOut,
   input  logic       sdaIn
);
   localparam int QW = $clog2(`SCL_QUARTER) + 1;

   logic          busy;
   byteCmd_e      mode;
   logic [QW-1:0] qCnt;        // cycles inside one quarter
   logic [1:0]    phase;       // quarter inside one bit
   logic [3:0]    bitCnt;      // 8 data bits then ack
   logic [7:0]    txReg;
   logic          accept;
   logic          tick;
   logic          lastStep;
   byteCmd_e      actMode;
   logic [1:0]    actPhase;
   logic [3:0]    actBit;
   logic [7:0]    actData;
   logic          actTx;

   assign accept   = cmdValid && !busy;
   assign tick     = busy && (qCnt == QW'(`SCL_QUARTER - 1));
   assign lastStep = (phase == 2'd3) && (mode == start || mode == stop || bitCnt == 4'd8);

   // slot that the next clock edge enters
   always_comb begin
      actMode  = busy ? mode : cmd;
      actPhase = busy ? phase + 2'd1 : 2'd0;
      actBit   = (busy && phase == 2'd3) ? bitCnt + 4'd1 : (busy ? bitCnt : 4'd0);
      actData  = accept ? txByte : txReg;
      actTx    = actData[3'd7 - actBit[2:0]];   // msb first
   end

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         busy    <= 1'b0;
         mode    <= start;
         qCnt    <= '0;
         phase   <= 2'd0;
         bitCnt  <= 4'd0;
         cmdDone <= 1'b0;
         sclOut  <= 1'b1;
         sdaOut  <= 1'b1;
      end else begin
         cmdDone <= 1'b0;
         if (accept) begin
            busy   <= 1'b1;
            mode   <= cmd;
            qCnt   <= '0;
            phase  <= 2'd0;
            bitCnt <= 4'd0;
         end else if (busy && !tick) begin
            qCnt <= qCnt + 1'b1;
         end else if (tick) begin
            qCnt <= '0;
            if (lastStep) begin
               busy    <= 1'b0;
               cmdDone <= 1'b1;
            end else begin
               phase  <= actPhase;
               bitCnt <= actBit;
            end
         end
         if (accept || (tick && !lastStep)) begin
            case (actMode)
               start: begin
                  case (actPhase)
                     2'd0:    sdaOut <= 1'b1;
                     2'd1:    sclOut <= 1'b1;
                     2'd2:    sdaOut <= 1'b0;   // start, sda falls with scl high
                     default: sclOut <= 1'b0;
                  endcase
               end
               stop: begin
                  case (actPhase)
                     2'd0:    sdaOut <= 1'b0;
                     2'd1:    sclOut <= 1'b1;
                     2'd2:    sdaOut <= 1'b1;   // stop, sda rises with scl high
                     default: ;
                  endcase
               end
               default: begin
                  case (actPhase)
                     2'd0:    sdaOut <= (actMode == sendByte && actBit < 4'd8) ? actTx : 1'b1;
                     2'd1:    sclOut <= 1'b1;
                     2'd2:    ;                 // sample point
                     default: sclOut <= 1'b0;
                  endcase
               end
            endcase
         end
      end
   end

   always_ff @(posedge CLK_400K) begin
      if (accept) txReg <= txByte;
      if (tick && !lastStep && actPhase == 2'd2 && (mode == sendByte || mode == recvByte)) begin
         if (actBit < 4'd8) rxByte <= {rxByte[6:0], sdaIn};
         else ackIn <= !sdaIn;   // low means acknowledged
      end
   end

endmodule

`default_nettype wire

//--- src/camCfgPkg.sv
`default_nettype none
`include "camCfg_params.svh"

package camCfgPkg;

   typedef enum logic [1:0] {writePtr, writeReg, readByte} i2cOp_e;

   typedef enum logic [1:0] {start, sendByte, recvByte, stop} byteCmd_e;

   typedef enum logic [1:0] {regWrite, delay, scriptEnd} entryKind_e;

   typedef enum logic [2:0] {
      idPtr, idRead, idCheck, fetch, regWr, delayWait, retryWait, cfgDone
   } seqState_e;

   typedef struct packed {
      i2cOp_e      op;
      logic [7:0]  devAddr;   // write form, bit 0 set by the transaction layer
      logic [15:0] regAddr;
      logic [7:0]  wrData;
   } i2cReq_t;

   typedef struct packed {
      logic [7:0]  rdData;
      logic        ackErr;    // some byte was not acknowledged
   } i2cRsp_t;

   typedef struct packed {
      entryKind_e  kind;
      logic [7:0]  devAddr;
      logic [15:0] regAddr;
      logic [7:0]  value;     // data byte or delay count
   } scriptEntry_t;

   localparam scriptEntry_t CAM_SCRIPT [0:11] = '{
      '{regWrite,  `CAM_I2C_ADDR, 16'h0103, 8'h01},   // software reset
      '{delay,     8'h00,         16'h0000, 8'd10},
      '{regWrite,  `CAM_I2C_ADDR, 16'h0100, 8'h00},   // standby
      '{regWrite,  `CAM_I2C_ADDR, 16'h0302, 8'd24},   // pll1 multiplier
      '{regWrite,  `CAM_I2C_ADDR, 16'h0303, 8'h00},   // pll1 divm
      '{regWrite,  `CAM_I2C_ADDR, 16'h0304, 8'd3},    // pll1 mipi div
      '{regWrite,  `CAM_I2C_ADDR, 16'h3808, 8'h02},   // x size high, 640
      '{regWrite,  `CAM_I2C_ADDR, 16'h3809, 8'h80},   // x size low
      '{regWrite,  `CAM_I2C_ADDR, 16'h380a, 8'h01},   // y size high, 480
      '{regWrite,  `CAM_I2C_ADDR, 16'h380b, 8'he0},   // y size low
      '{regWrite,  `CAM_I2C_ADDR, 16'h0100, 8'h01},   // streaming on
      '{scriptEnd, 8'h00,         16'h0000, 8'h00}
   };

endpackage

`default_nettype wire

//--- src/camCfg_params.svh
`ifndef CAMCFG_PARAMS_SVH
`define CAMCFG_PARAMS_SVH

// sensor bus address and identity
`define CAM_I2C_ADDR   8'h6c     // 7-bit 0x36, write form
`define CAM_ID_REG     16'h300b  // chip id register
`define CAM_ID_VALUE   8'h88     // expected id byte

// bus timing, in CLK_400K cycles
`define SCL_QUARTER    1         // quarter of one scl bit

// sequencer timing, in CLK_400K cycles
`define DELAY_UNIT     16        // per script delay count
`define RETRY_WAIT     8         // idle before a new id check

`endif
